// File: common/rv_pkg.sv
package rv_pkg;

	localparam int XLEN     = 32;
	localparam int REG_W    = 5;
	localparam int NUM_REGS = 32;

	// instruction field positions
	localparam int OP_LSB  = 0;
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB  = 25;

	typedef logic [XLEN-1:0]  word_t;     // data, pc, instr
	typedef logic [REG_W-1:0] reg_addr_t;
	typedef logic [6:0]       opcode_t;
	typedef logic [3:0]       alu_fn_t;    // {instr[30], funct3}
	typedef logic [3:0]       mem_op_t;    // {store, size[1:0], signed}
	typedef logic [2:0]       muldiv_op_t;
	typedef logic [2:0]       wb_sel_t;    // decoder fn code
	typedef logic [1:0]       b_sel_t;

	// major opcodes, used where a format has to be picked
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;

	localparam alu_fn_t ALU_ADD  = 4'b0000;
	localparam alu_fn_t ALU_SLL  = 4'b0001;
	localparam alu_fn_t ALU_SLT  = 4'b0010; // also blt
	localparam alu_fn_t ALU_SLTU = 4'b0011; // also bltu
	localparam alu_fn_t ALU_XOR  = 4'b0100;
	localparam alu_fn_t ALU_SRL  = 4'b0101;
	localparam alu_fn_t ALU_OR   = 4'b0110;
	localparam alu_fn_t ALU_AND  = 4'b0111;
	localparam alu_fn_t ALU_SUB  = 4'b1000; // also beq / bne
	localparam alu_fn_t ALU_GE   = 4'b1001;
	localparam alu_fn_t ALU_GEU  = 4'b1010;
	localparam alu_fn_t ALU_SRA  = 4'b1101;

	localparam wb_sel_t WB_ALU   = 3'b000;
	localparam wb_sel_t WB_PC4   = 3'b001;
	localparam wb_sel_t WB_IMM   = 3'b011;
	localparam wb_sel_t WB_AUIPC = 3'b100;

	localparam b_sel_t B_REG   = 2'b00;
	localparam b_sel_t B_IMM   = 2'b01;
	localparam b_sel_t B_SHAMT = 2'b10;

	localparam mem_op_t MEM_NONE = 4'b0000;

	typedef struct packed {
		logic       we;
		b_sel_t     b_sel;
		wb_sel_t    wb_sel;
		alu_fn_t    alu_fn;
		logic       jal;
		logic       jalr;
		logic       branch;
		logic       bneq;
		logic       lui;
		logic       auipc;
		mem_op_t    mem_op;
		muldiv_op_t muldiv_op;
		logic       is_muldiv;
	} ctrl_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} wb_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic       valid;
		logic       is_mem;     // clear for mul/div
		mem_op_t    mem_op;
		muldiv_op_t muldiv_op;
		reg_addr_t  rd;
		word_t      a;          // address or rs1
		word_t      b;          // store data or rs2
	} req_t;

endpackage

// File: decode/instr_decoder.sv
module instr_decoder (
	input  rv_pkg::opcode_t i_op,
	input  logic [2:0]      i_funct3,
	input  logic [6:0]      i_funct7,
	output rv_pkg::ctrl_t   o_ctrl
);
	import rv_pkg::*;

	logic rtype, itype, ltype, stype, btype, jtype, jrtype, utype, autype;
	logic md_f7, alu_r, bit30;
	logic r_add, r_sub, r_sll, r_slt, r_sltu, r_xor, r_srl, r_sra, r_or, r_and;
	logic m_mul, m_mulh, m_mulhsu, m_mulhu, m_div, m_divu, m_rem, m_remu;
	logic im_addi, im_slti, im_sltiu, im_xori, im_ori, im_andi, im_slli, im_srli, im_srai;
	logic b_eq, b_ne, b_lt, b_ge, b_ltu, b_geu;
	logic ld_b, ld_h, ld_w, ld_bu, ld_hu, st_b, st_h, st_w;
	logic dec_jalr, r_any, m_any, im_any, ld_any;

	assign bit30 = i_funct7[5];
	assign md_f7 = (~|i_funct7[6:1]) & i_funct7[0]; // funct7 0000001

	// opcode classes
	assign rtype  = ~i_op[6] &  i_op[5] &  i_op[4] & ~i_op[3] & ~i_op[2] & i_op[1] & i_op[0];
	assign itype  = ~i_op[6] & ~i_op[5] &  i_op[4] & ~i_op[3] & ~i_op[2] & i_op[1] & i_op[0];
	assign ltype  = ~i_op[6] & ~i_op[5] & ~i_op[4] & ~i_op[3] & ~i_op[2] & i_op[1] & i_op[0];
	assign stype  = ~i_op[6] &  i_op[5] & ~i_op[4] & ~i_op[3] & ~i_op[2] & i_op[1] & i_op[0];
	assign btype  =  i_op[6] &  i_op[5] & ~i_op[4] & ~i_op[3] & ~i_op[2] & i_op[1] & i_op[0];
	assign jtype  =  i_op[6] &  i_op[5] & ~i_op[4] &  i_op[3] &  i_op[2] & i_op[1] & i_op[0];
	assign jrtype =  i_op[6] &  i_op[5] & ~i_op[4] & ~i_op[3] &  i_op[2] & i_op[1] & i_op[0];
	assign utype  = ~i_op[6] &  i_op[5] &  i_op[4] & ~i_op[3] &  i_op[2] & i_op[1] & i_op[0];
	assign autype = ~i_op[6] & ~i_op[5] &  i_op[4] & ~i_op[3] &  i_op[2] & i_op[1] & i_op[0];

	assign alu_r = rtype & ~md_f7; // keep mul/div out of the alu decode

	// reg-reg alu ops                                                     bit30 funct3
	assign r_add  = alu_r & ~bit30 & ~|i_funct3;                            // 0 000
	assign r_sub  = alu_r &  bit30 & ~|i_funct3;                            // 1 000
	assign r_sll  = alu_r & ~bit30 & ~i_funct3[2] & ~i_funct3[1] &  i_funct3[0]; // 0 001
	assign r_slt  = alu_r & ~bit30 & ~i_funct3[2] &  i_funct3[1] & ~i_funct3[0]; // 0 010
	assign r_sltu = alu_r & ~bit30 & ~i_funct3[2] &  i_funct3[1] &  i_funct3[0]; // 0 011
	assign r_xor  = alu_r & ~bit30 &  i_funct3[2] & ~i_funct3[1] & ~i_funct3[0]; // 0 100
	assign r_srl  = alu_r & ~bit30 &  i_funct3[2] & ~i_funct3[1] &  i_funct3[0]; // 0 101
	assign r_sra  = alu_r &  bit30 &  i_funct3[2] & ~i_funct3[1] &  i_funct3[0]; // 1 101
	assign r_or   = alu_r & ~bit30 &  i_funct3[2] &  i_funct3[1] & ~i_funct3[0]; // 0 110
	assign r_and  = alu_r & ~bit30 & (&i_funct3);                           // 0 111

	// mul / div, funct3 picks the op
	assign m_mul    = rtype & md_f7 & ~|i_funct3;
	assign m_mulh   = rtype & md_f7 & ~i_funct3[2] & ~i_funct3[1] &  i_funct3[0];
	assign m_mulhsu = rtype & md_f7 & ~i_funct3[2] &  i_funct3[1] & ~i_funct3[0];
	assign m_mulhu  = rtype & md_f7 & ~i_funct3[2] &  i_funct3[1] &  i_funct3[0];
	assign m_div    = rtype & md_f7 &  i_funct3[2] & ~i_funct3[1] & ~i_funct3[0];
	assign m_divu   = rtype & md_f7 &  i_funct3[2] & ~i_funct3[1] &  i_funct3[0];
	assign m_rem    = rtype & md_f7 &  i_funct3[2] &  i_funct3[1] & ~i_funct3[0];
	assign m_remu   = rtype & md_f7 & (&i_funct3);

	// reg-imm ops, bit30 only matters for the shifts
	assign im_addi  = itype & ~|i_funct3;
	assign im_slti  = itype & ~i_funct3[2] &  i_funct3[1] & ~i_funct3[0];
	assign im_sltiu = itype & ~i_funct3[2] &  i_funct3[1] &  i_funct3[0];
	assign im_xori  = itype &  i_funct3[2] & ~i_funct3[1] & ~i_funct3[0];
	assign im_ori   = itype &  i_funct3[2] &  i_funct3[1] & ~i_funct3[0];
	assign im_andi  = itype & (&i_funct3);
	assign im_slli  = itype & ~bit30 & ~i_funct3[2] & ~i_funct3[1] & i_funct3[0];
	assign im_srli  = itype & ~bit30 &  i_funct3[2] & ~i_funct3[1] & i_funct3[0];
	assign im_srai  = itype &  bit30 &  i_funct3[2] & ~i_funct3[1] & i_funct3[0];

	// branches
	assign b_eq  = btype & ~|i_funct3;                                // 000
	assign b_ne  = btype & ~i_funct3[2] & ~i_funct3[1] &  i_funct3[0]; // 001
	assign b_lt  = btype &  i_funct3[2] & ~i_funct3[1] & ~i_funct3[0]; // 100
	assign b_ge  = btype &  i_funct3[2] & ~i_funct3[1] &  i_funct3[0]; // 101
	assign b_ltu = btype &  i_funct3[2] &  i_funct3[1] & ~i_funct3[0]; // 110
	assign b_geu = btype & (&i_funct3);                               // 111

	assign dec_jalr = jrtype & ~|i_funct3;

	// loads and stores
	assign ld_b  = ltype & ~i_funct3[2] & ~i_funct3[1] & ~i_funct3[0];
	assign ld_h  = ltype & ~i_funct3[2] & ~i_funct3[1] &  i_funct3[0];
	assign ld_w  = ltype & ~i_funct3[2] &  i_funct3[1] & ~i_funct3[0];
	assign ld_bu = ltype &  i_funct3[2] & ~i_funct3[1] & ~i_funct3[0];
	assign ld_hu = ltype &  i_funct3[2] & ~i_funct3[1] &  i_funct3[0];
	assign st_b  = stype & ~i_funct3[2] & ~i_funct3[1] & ~i_funct3[0];
	assign st_h  = stype & ~i_funct3[2] & ~i_funct3[1] &  i_funct3[0];
	assign st_w  = stype & ~i_funct3[2] &  i_funct3[1] & ~i_funct3[0];

	assign r_any  = r_add | r_sub | r_sll | r_slt | r_sltu | r_xor | r_srl | r_sra | r_or | r_and;
	assign m_any  = m_mul | m_mulh | m_mulhsu | m_mulhu | m_div | m_divu | m_rem | m_remu;
	assign im_any = im_addi | im_slti | im_sltiu | im_xori | im_ori | im_andi
		| im_slli | im_srli | im_srai;
	assign ld_any = ld_b | ld_h | ld_w | ld_bu | ld_hu;

	// only recognised instrs write, unknown opcodes leave everything low
	assign o_ctrl.we = r_any | m_any | im_any | ld_any | jtype | dec_jalr | utype | autype;

	assign o_ctrl.b_sel[0] = im_addi | im_slti | im_sltiu | im_xori | im_ori | im_andi
		| dec_jalr | ld_any | st_b | st_h | st_w; // rs1 + imm for addresses too
	assign o_ctrl.b_sel[1] = im_slli | im_srli | im_srai;

	// 000 alu, 001 pc+4, 010 mul/div, 011 imm, 100 auipc, 111 load
	assign o_ctrl.wb_sel[0] = jtype | dec_jalr | utype | ld_any;
	assign o_ctrl.wb_sel[1] = m_any | utype | ld_any;
	assign o_ctrl.wb_sel[2] = ld_any | autype;

	assign o_ctrl.alu_fn[0] = r_sll | im_slli | r_sltu | im_sltiu | r_srl | im_srli
		| r_and | im_andi | r_sra | im_srai | b_ltu | b_ge;
	assign o_ctrl.alu_fn[1] = r_slt | im_slti | r_sltu | im_sltiu | r_or | im_ori
		| r_and | im_andi | b_lt | b_ltu | b_geu;
	assign o_ctrl.alu_fn[2] = r_xor | im_xori | r_srl | im_srli | r_or | im_ori
		| r_and | im_andi | r_sra | im_srai;
	assign o_ctrl.alu_fn[3] = r_sub | r_sra | im_srai | b_eq | b_ne | b_ge | b_geu;

	assign o_ctrl.jal    = jtype;
	assign o_ctrl.jalr   = dec_jalr;
	assign o_ctrl.branch = b_eq | b_ne | b_lt | b_ge | b_ltu | b_geu;
	assign o_ctrl.bneq   = b_ne;   // flips the alu zero test
	assign o_ctrl.lui    = utype;
	assign o_ctrl.auipc  = autype;

	// {store, size, signed}: word 11, half 01, byte 10
	assign o_ctrl.mem_op[0] = st_w | st_h | st_b | ld_w | ld_h | ld_b;
	assign o_ctrl.mem_op[1] = st_w | st_h | ld_w | ld_h | ld_hu;
	assign o_ctrl.mem_op[2] = st_w | st_b | ld_w | ld_b | ld_bu;
	assign o_ctrl.mem_op[3] = st_w | st_h | st_b;

	// div 101, divu 100, rem 111, remu 110, mul* follow funct3
	assign o_ctrl.muldiv_op[0] = m_div | m_rem | m_mulh | m_mulhu;
	assign o_ctrl.muldiv_op[1] = m_remu | m_rem | m_mulhsu | m_mulhu;
	assign o_ctrl.muldiv_op[2] = m_div | m_divu | m_rem | m_remu;
	assign o_ctrl.is_muldiv    = m_any;

endmodule

// File: decode/imm_gen.sv
module imm_gen (
	input  rv_pkg::word_t i_instr,
	output rv_pkg::word_t o_imm
);
	import rv_pkg::*;

	opcode_t op;
	logic    sign;

	assign op   = i_instr[OP_LSB +: 7];
	assign sign = i_instr[XLEN-1]; // imm sign always sits in bit 31

	always_comb begin
		case (op)
			// I format, shifts land their shamt in [4:0]
			OP_IMM, OP_LOAD, OP_JALR: begin
				o_imm = {{20{sign}}, i_instr[31:20]};
			end
			OP_STORE: begin
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			end
			OP_BRANCH: begin
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			end
			OP_LUI, OP_AUIPC: begin
				o_imm = {i_instr[31:12], 12'b0}; // upper 20 bits
			end
			OP_JAL: begin
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			end
			default: begin
				o_imm = '0;
			end
		endcase
	end

endmodule

// File: logic/reg_file.sv
module reg_file (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_we,
	input  rv_pkg::reg_addr_t i_waddr,
	input  rv_pkg::reg_addr_t i_raddr1,
	input  rv_pkg::reg_addr_t i_raddr2,
	input  rv_pkg::word_t     i_wdata,
	output rv_pkg::word_t     o_rdata1,
	output rv_pkg::word_t     o_rdata2
);
	import rv_pkg::*;

	word_t regs [1:NUM_REGS-1]; // no storage behind x0

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_waddr != '0) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// async read ports
	assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
	assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: logic/alu.sv
module alu (
	input  rv_pkg::word_t   i_a,
	input  rv_pkg::word_t   i_b,
	input  rv_pkg::alu_fn_t i_fn,
	input  logic            i_bneq,
	output rv_pkg::word_t   o_result,
	output logic            o_taken
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = i_b[4:0];
	assign lt_s  = $signed(i_a) < $signed(i_b);
	assign lt_u  = i_a < i_b;

	always_comb begin
		case (i_fn)
			ALU_ADD:  o_result = i_a + i_b;
			ALU_SUB:  o_result = i_a - i_b;  // zero when equal
			ALU_SLL:  o_result = i_a << shamt;
			ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_SRL:  o_result = i_a >> shamt;
			ALU_SRA:  o_result = $signed(i_a) >>> shamt;
			ALU_OR:   o_result = i_a | i_b;
			ALU_AND:  o_result = i_a & i_b;
			ALU_GE:   o_result = {{(XLEN-1){1'b0}}, ~lt_s};
			ALU_GEU:  o_result = {{(XLEN-1){1'b0}}, ~lt_u};
			default:  o_result = '0;
		endcase
	end

	// branch condition, only looked at for branches
	always_comb begin
		case (i_fn)
			ALU_SUB: begin
				o_taken = (o_result == '0) ^ i_bneq; // beq, bne inverted
			end
			ALU_SLT, ALU_SLTU, ALU_GE, ALU_GEU: begin
				o_taken = o_result[0];
			end
			default: begin
				o_taken = 1'b0;
			end
		endcase
	end

endmodule

// File: logic/int_exec.sv
module int_exec (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_valid,     // one-cycle issue strobe
	input  rv_pkg::word_t     i_instr,
	input  rv_pkg::word_t     i_pc,
	output rv_pkg::wb_t       o_wb,
	output rv_pkg::redirect_t o_redirect,
	output rv_pkg::req_t      o_req
);
	import rv_pkg::*;

	ctrl_t     ctrl;
	reg_addr_t rd, rs1, rs2;
	word_t     imm, rs1_val, rs2_val, op_b, alu_res;
	word_t     pc_imm, pc_4, wb_data, target;
	logic      taken, is_mem, rf_we, redirect, req;

	assign rd  = i_instr[RD_LSB +: REG_W];
	assign rs1 = i_instr[RS1_LSB +: REG_W];
	assign rs2 = i_instr[RS2_LSB +: REG_W];

	instr_decoder decoder_inst (
		.i_op     (i_instr[OP_LSB +: 7]),
		.i_funct3 (i_instr[F3_LSB +: 3]),
		.i_funct7 (i_instr[F7_LSB +: 7]),
		.o_ctrl   (ctrl)
	);

	imm_gen imm_gen_inst (.i_instr(i_instr), .o_imm(imm));

	reg_file reg_file_inst (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_we     (rf_we),
		.i_waddr  (rd),
		.i_raddr1 (rs1),
		.i_raddr2 (rs2),
		.i_wdata  (wb_data),
		.o_rdata1 (rs1_val),
		.o_rdata2 (rs2_val)
	);

	alu alu_inst (
		.i_a      (rs1_val),
		.i_b      (op_b),
		.i_fn     (ctrl.alu_fn),
		.i_bneq   (ctrl.bneq),
		.o_result (alu_res),
		.o_taken  (taken)
	);

	always_comb begin
		case (ctrl.b_sel)
			B_IMM:   op_b = imm;
			B_SHAMT: op_b = word_t'(imm[4:0]); // drop the funct7 bits of srai
			default: op_b = rs2_val;
		endcase
	end

	assign pc_imm = i_pc + imm;        // jal / branch target, auipc result
	assign pc_4   = i_pc + word_t'(4);

	always_comb begin
		case (ctrl.wb_sel)
			WB_PC4:   wb_data = pc_4;    // link
			WB_IMM:   wb_data = imm;     // lui
			WB_AUIPC: wb_data = pc_imm;
			default:  wb_data = alu_res;
		endcase
	end

	assign is_mem = ctrl.mem_op != MEM_NONE;
	// loads and mul/div come back from outside, not written here
	assign rf_we    = i_valid & ctrl.we & (rd != '0) & ~is_mem & ~ctrl.is_muldiv;
	assign redirect = i_valid & (ctrl.jal | ctrl.jalr | (ctrl.branch & taken));
	assign req      = i_valid & (is_mem | ctrl.is_muldiv);
	assign target   = ctrl.jalr ? {alu_res[XLEN-1:1], 1'b0} : pc_imm;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_wb       <= '0;
			o_redirect <= '0;
			o_req      <= '0;
		end else begin
			o_wb.valid       <= rf_we;
			o_redirect.valid <= redirect;
			o_req.valid      <= req;
			if (i_valid) begin
				o_wb.rd           <= rd;
				o_wb.data         <= wb_data;
				o_redirect.target <= target;
				o_req.is_mem      <= is_mem;
				o_req.mem_op      <= ctrl.mem_op;
				o_req.muldiv_op   <= ctrl.muldiv_op;
				o_req.rd          <= rd;
				o_req.a           <= is_mem ? alu_res : rs1_val; // addr from alu
				o_req.b           <= rs2_val;
			end
		end
	end

endmodule

// File: dv/tb_clock.sv
module tb_clock (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period, first rising edge at 20 ns
	initial begin
		o_clk = 1'b0;
		forever begin
			#20 o_clk = ~o_clk;
		end
	end

endmodule

// File: dv/tb_int_exec.sv
module tb_int_exec;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_pkg::*;

	typedef struct packed {
		wb_t       wb;
		redirect_t red;
		req_t      req;
		logic      use_rd; // stores carry no rd
		logic      use_b;  // loads carry no data
	} exp_t;

	localparam int ISSUE_COUNT = 351; // instrs issued by the stimulus below
	localparam int WATCHDOG_NS = (ISSUE_COUNT + 8 + 100) * 40;

	logic      clk, rst, issue_valid;
	word_t     issue_instr, issue_pc, pc, seed, w;
	wb_t       o_wb;
	redirect_t o_redirect;
	req_t      o_req;
	exp_t      nx, pend, chk; // next, in flight, checked now
	word_t     shadow [32];
	int        val_errs, vld_errs;

	tb_clock clock_inst (.o_clk(clk));

	int_exec int_exec_inst (
		.i_clk (clk), .i_reset (rst), .i_valid (issue_valid),
		.i_instr (issue_instr), .i_pc (issue_pc),
		.o_wb (o_wb), .o_redirect (o_redirect), .o_req (o_req)
	);

	function automatic word_t rand32();
		seed = seed ^ (seed << 13); // xorshift32
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic word_t sext12(input logic [11:0] x);
		return {{20{x[11]}}, x};
	endfunction

	// rv32i semantics, alt is instr bit 30
	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input word_t a, b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// {store, size, signed}, size word 11 half 01 byte 10
	function automatic mem_op_t mem_code(input logic store, input logic [2:0] f3);
		logic [1:0] size;
		size = (f3[1:0] == 2'b00) ? 2'b10 : (f3[1:0] == 2'b01) ? 2'b01 : 2'b11;
		return store ? {1'b1, size, 1'b1} : {1'b0, size, ~f3[2]};
	endfunction

	function automatic muldiv_op_t md_code(input logic [2:0] f3);
		case (f3)
			3'd4: return 3'b101; // div
			3'd5: return 3'b100; // divu
			3'd6: return 3'b111; // rem
			3'd7: return 3'b110; // remu
			default: return f3;  // mul family
		endcase
	endfunction

	task automatic send(input word_t instr);
		@(posedge clk);
		#5;
		issue_valid = 1'b1;
		issue_instr = instr;
		issue_pc    = pc;
		pend        = nx;
		if (nx.wb.valid) begin
			shadow[nx.wb.rd] = nx.wb.data;
		end
		pc = pc + 32'd4;
		nx = '0;
	endtask

	task automatic expect_wb(input reg_addr_t rd, input word_t data);
		nx.wb.valid = (rd != 5'd0); // x0 never written
		nx.wb.rd    = rd;
		nx.wb.data  = data;
	endtask

	task automatic alu_rr(input logic [2:0] f3, input logic alt, input reg_addr_t rd, rs1, rs2);
		expect_wb(rd, alu_ref(f3, alt, shadow[rs1], shadow[rs2]));
		send({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
	endtask

	task automatic alu_ri(input logic [2:0] f3, input logic alt, input reg_addr_t rd, rs1,
		input logic [11:0] imm);
		logic [11:0] i;
		i = (f3[1:0] == 2'b01) ? {1'b0, alt, 5'b0, imm[4:0]} : imm; // shifts
		expect_wb(rd, alu_ref(f3, alt, shadow[rs1], sext12(i)));
		send({i, rs1, f3, rd, 7'b0010011});
	endtask

	task automatic load_reg(input reg_addr_t rd, input word_t value);
		word_t hi;
		hi = (value + 32'h800) >> 12; // addi sign compensation
		expect_wb(rd, {hi[19:0], 12'b0});
		send({hi[19:0], rd, 7'b0110111});
		alu_ri(3'd0, 1'b0, rd, rd, value[11:0]);
	endtask

	task automatic upper(input logic auipc, input reg_addr_t rd, input logic [19:0] imm);
		expect_wb(rd, {imm, 12'b0} + (auipc ? pc : 32'd0));
		send({imm, rd, auipc ? 7'b0010111 : 7'b0110111});
	endtask

	task automatic jal_op(input reg_addr_t rd, input logic [20:0] off);
		expect_wb(rd, pc + 32'd4);
		nx.red.valid  = 1'b1;
		nx.red.target = pc + {{11{off[20]}}, off};
		send({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111});
	endtask

	task automatic jalr_op(input reg_addr_t rd, rs1, input logic [11:0] imm);
		nx.red.valid  = 1'b1;
		nx.red.target = (shadow[rs1] + sext12(imm)) & 32'hffff_fffe;
		expect_wb(rd, pc + 32'd4);
		send({imm, rs1, 3'b000, rd, 7'b1100111});
	endtask

	task automatic branch_op(input logic [2:0] f3, input reg_addr_t rs1, rs2,
		input logic [12:0] off);
		nx.red.valid  = branch_ref(f3, shadow[rs1], shadow[rs2]);
		nx.red.target = pc + {{19{off[12]}}, off};
		send({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011});
	endtask

	task automatic mem_access(input logic store, input logic [2:0] f3,
		input reg_addr_t rd, rs1, rs2, input logic [11:0] imm);
		nx.req.valid  = 1'b1;
		nx.req.is_mem = 1'b1;
		nx.req.mem_op = mem_code(store, f3);
		nx.req.rd     = rd;
		nx.req.a      = shadow[rs1] + sext12(imm);
		nx.req.b      = shadow[rs2];
		nx.use_rd     = ~store;
		nx.use_b      = store;
		if (store) begin
			send({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011});
		end else begin
			send({imm, rs1, f3, rd, 7'b0000011});
		end
	endtask

	task automatic muldiv(input logic [2:0] f3, input reg_addr_t rd, rs1, rs2);
		nx.req.valid     = 1'b1;
		nx.req.muldiv_op = md_code(f3);
		nx.req.rd        = rd;
		nx.req.a         = shadow[rs1];
		nx.req.b         = shadow[rs2];
		nx.use_rd        = 1'b1;
		nx.use_b         = 1'b1;
		send({7'b0000001, rs2, rs1, f3, rd, 7'b0110011});
	endtask

	always @(posedge clk) begin
		chk <= pend; // outputs for this issue show up after this edge
	end

	// outputs settled mid-cycle, compare at the falling edge
	a_wb_vld: assert property (@(negedge clk) disable iff (rst) o_wb.valid == chk.wb.valid)
		else begin
			vld_errs++;
			$display("writeback pulse %s", chk.wb.valid ? "missing" : "unexpected");
		end
	a_wb_rd: assert property (@(negedge clk) disable iff (rst)
		!(chk.wb.valid && o_wb.valid) || o_wb.rd == chk.wb.rd)
		else begin
			val_errs++;
			$display("ERROR o_wb.rd got %h expected %h", o_wb.rd, chk.wb.rd);
		end
	a_wb_data: assert property (@(negedge clk) disable iff (rst)
		!(chk.wb.valid && o_wb.valid) || o_wb.data == chk.wb.data)
		else begin
			val_errs++;
			$display("ERROR o_wb.data got %h expected %h", o_wb.data, chk.wb.data);
		end
	a_red_vld: assert property (@(negedge clk) disable iff (rst)
		o_redirect.valid == chk.red.valid)
		else begin
			vld_errs++;
			$display("redirect pulse %s", chk.red.valid ? "missing" : "unexpected");
		end
	a_red_tgt: assert property (@(negedge clk) disable iff (rst)
		!(chk.red.valid && o_redirect.valid) || o_redirect.target == chk.red.target)
		else begin
			val_errs++;
			$display("ERROR o_redirect.target got %h expected %h",
				o_redirect.target, chk.red.target);
		end
	a_req_vld: assert property (@(negedge clk) disable iff (rst) o_req.valid == chk.req.valid)
		else begin
			vld_errs++;
			$display("request pulse %s", chk.req.valid ? "missing" : "unexpected");
		end
	a_req_kind: assert property (@(negedge clk) disable iff (rst)
		!(chk.req.valid && o_req.valid)
		|| {o_req.is_mem, o_req.mem_op, o_req.muldiv_op}
		== {chk.req.is_mem, chk.req.mem_op, chk.req.muldiv_op})
		else begin
			val_errs++;
			$display("ERROR o_req.is_mem/mem_op/muldiv_op got %h expected %h",
				{o_req.is_mem, o_req.mem_op, o_req.muldiv_op},
				{chk.req.is_mem, chk.req.mem_op, chk.req.muldiv_op});
		end
	a_req_rd: assert property (@(negedge clk) disable iff (rst)
		!(chk.req.valid && chk.use_rd && o_req.valid) || o_req.rd == chk.req.rd)
		else begin
			val_errs++;
			$display("ERROR o_req.rd got %h expected %h", o_req.rd, chk.req.rd);
		end
	a_req_a: assert property (@(negedge clk) disable iff (rst)
		!(chk.req.valid && o_req.valid) || o_req.a == chk.req.a)
		else begin
			val_errs++;
			$display("ERROR o_req.a got %h expected %h", o_req.a, chk.req.a);
		end
	a_req_b: assert property (@(negedge clk) disable iff (rst)
		!(chk.req.valid && chk.use_b && o_req.valid) || o_req.b == chk.req.b)
		else begin
			val_errs++;
			$display("ERROR o_req.b got %h expected %h", o_req.b, chk.req.b);
		end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the stimulus did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_instr = '0;
		issue_pc = '0;
		pc = 32'h0000_1000;
		seed = 32'h07f2_00aa;
		nx = '0;
		pend = '0;
		val_errs = 0;
		vld_errs = 0;
		foreach (shadow[i]) shadow[i] = '0;
		repeat (8) @(posedge clk);
		#5 rst = 1'b0;
		for (int r = 1; r < 32; r++) alu_rr(3'd0, 1'b0, reg_addr_t'(r), reg_addr_t'(r), 5'd0);
		for (int r = 1; r < 8; r++) load_reg(reg_addr_t'(r), rand32());
		alu_ri(3'd0, 1'b0, 5'd0, 5'd1, 12'h123); // x0 target, no writeback
		for (int n = 0; n < 120; n++) begin
			if (n % 16 == 0) load_reg({2'b0, n[6:4]} + 5'd1, rand32()); // keep operands wide
			w = rand32();
			if (w[31]) alu_rr(w[2:0], w[3] & (w[2:0] == 3'd0 || w[2:0] == 3'd5),
				{2'b0, w[6:4]}, {2'b0, w[9:7]}, {2'b0, w[12:10]});
			else alu_ri(w[2:0], w[3] & (w[2:0] == 3'd5), {2'b0, w[6:4]}, {2'b0, w[9:7]}, w[24:13]);
		end
		for (int n = 0; n < 8; n++) begin
			w = rand32();
			upper(1'b0, {2'b0, w[2:0]}, w[31:12]);
			upper(1'b1, {2'b0, w[5:3]}, w[30:11]);
			jal_op({2'b0, w[8:6]}, {w[20:1], 1'b0});
			jalr_op({2'b0, w[11:9]}, {2'b0, w[14:12]}, w[31:20]);
		end
		alu_ri(3'd0, 1'b0, 5'd6, 5'd5, 12'h000); // x6 = x5 for equal compares
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				for (int k = 0; k < 12; k++) begin
					w = rand32();
					branch_op(f[2:0], {2'b0, w[2:0]}, {2'b0, w[5:3]}, {w[17:6], 1'b0});
				end
			end
		end
		for (int f = 0; f < 8; f++) begin
			for (int k = 0; k < 6; k++) begin
				w = rand32();
				if (f < 3) mem_access(1'b1, f[2:0], 5'd0, {2'b0, w[2:0]}, {2'b0, w[5:3]}, w[31:20]);
				else mem_access(1'b0, (f < 6) ? f[2:0] - 3'd3 : f[2:0] - 3'd2, // lb lh lw lbu lhu
					{2'b0, w[8:6]}, {2'b0, w[2:0]}, {2'b0, w[5:3]}, w[31:20]);
			end
		end
		for (int f = 0; f < 16; f++) begin
			w = rand32();
			muldiv(f[2:0], {2'b0, w[2:0]}, {2'b0, w[5:3]}, {2'b0, w[8:6]});
		end
		@(posedge clk);
		#5;
		issue_valid = 1'b0;
		pend = '0;
		repeat (3) @(posedge clk);
		$display("checks done: %0d value errors, %0d valid errors", val_errs, vld_errs);
		if (val_errs == 0 && vld_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
common/rv_pkg.sv
decode/instr_decoder.sv
decode/imm_gen.sv
logic/reg_file.sv
logic/alu.sv
logic/int_exec.sv
dv/tb_clock.sv
dv/tb_int_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_int_exec \
	-f filelist.f -Mdir obj_dir -o sim_int_exec > build.log 2>&1 \
	&& ./obj_dir/sim_int_exec > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
